// File: src/mem_ctl_pkg.sv
// Memory map, SPI commands, request and response structs, byte-lane helper functions
package mem_ctl_pkg;

    // Region tags, compared on the top address byte
    localparam logic [7:0] FLASH_BASE = 8'h80;
    localparam logic [7:0] PSRAM_BASE = 8'h00;

    // GPIO page, compared on address bits 31:8
    localparam logic [23:0] GPIO_BASE = 24'h40_0000;
    localparam int GPIO_WIDTH = 8;

    localparam logic [7:0] CMD_READ = 8'h03;
    localparam logic [7:0] CMD_WRITE = 8'h02;

    localparam int SPI_ADDR_W = 24;

    // funct3 of a full word access, also used for instruction fetch
    localparam logic [2:0] F3_WORD = 3'b010;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [2:0] funct3;
        logic we;
        logic re;
    } data_req_t;

    typedef struct packed {
        logic start;
        logic stop;
        logic cont;
        logic write;
        logic [SPI_ADDR_W-1:0] addr;
        logic [5:0] len;
        logic [31:0] wdata;
    } spi_req_t;

    typedef struct packed {
        logic done;
        logic [31:0] rdata;
    } spi_rsp_t;

    // Lowest byte goes out first, left aligned for an MSB-first shifter
    function automatic logic [31:0] store_lanes(input logic [31:0] wdata, input logic [2:0] funct3);
        case (funct3[1:0])
            2'b00: store_lanes = {wdata[7:0], 24'h0};
            2'b01: store_lanes = {wdata[7:0], wdata[15:8], 16'h0};
            default: store_lanes = {wdata[7:0], wdata[15:8], wdata[23:16], wdata[31:24]};
        endcase
    endfunction

    // Received bits sit right aligned; signed loads are zero-extended too
    function automatic logic [31:0] load_extend(input logic [31:0] rdata, input logic [2:0] funct3);
        case (funct3[1:0])
            2'b00: load_extend = {24'h0, rdata[7:0]};
            2'b01: load_extend = {16'h0, rdata[7:0], rdata[15:8]};
            default: load_extend = {rdata[7:0], rdata[15:8], rdata[23:16], rdata[31:24]};
        endcase
    endfunction

    function automatic logic [5:0] data_len_bits(input logic [2:0] funct3);
        case (funct3[1:0])
            2'b00: data_len_bits = 6'd8;
            2'b01: data_len_bits = 6'd16;
            default: data_len_bits = 6'd32;
        endcase
    endfunction

endpackage

// File: src/spi_master.sv
// Single-line SPI master with command, address and data phases and read burst continuation
`timescale 1ns/1ps

module spi_master import mem_ctl_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    input  spi_req_t req,
    input  logic fetch_active,
    input  logic data_in_flash,
    output spi_rsp_t rsp,

    output logic flash_cs_n,
    output logic ram_cs_n,
    output logic spi_sclk,
    input  logic [3:0] spi_io_in,
    output logic [3:0] spi_io_out,
    output logic [3:0] spi_io_oe
);

    logic busy;
    logic cs_active;
    logic sel_flash;
    logic burst;
    logic sclk_q;
    logic done_q;
    logic [6:0] bit_cnt;
    // Command, address and write data in one MSB-first word
    logic [63:0] shift_out;
    logic [31:0] shift_in;

    logic last_edge;

    // Falling edge of the final bit of the current transfer
    assign last_edge = busy && sclk_q && (bit_cnt == 7'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cs_active <= 1'b0;
            sel_flash <= 1'b0;
            burst <= 1'b0;
            sclk_q <= 1'b0;
            done_q <= 1'b0;
            bit_cnt <= 7'd0;
        end else begin
            done_q <= 1'b0;
            if (req.stop) begin
                busy <= 1'b0;
                cs_active <= 1'b0;
                sclk_q <= 1'b0;
            end else if (req.start) begin
                busy <= 1'b1;
                cs_active <= 1'b1;
                // Select is latched so the arbiter flags may change mid-transfer
                sel_flash <= fetch_active | data_in_flash;
                burst <= fetch_active;
                sclk_q <= 1'b0;
                bit_cnt <= 7'd32 + {1'b0, req.len};
            end else if (req.cont && cs_active && !busy) begin
                // Address counter in the device keeps running, so no new command
                busy <= 1'b1;
                bit_cnt <= 7'd32;
            end else if (busy) begin
                if (!sclk_q) begin
                    sclk_q <= 1'b1;
                end else begin
                    sclk_q <= 1'b0;
                    bit_cnt <= bit_cnt - 7'd1;
                    if (last_edge) begin
                        busy <= 1'b0;
                        done_q <= 1'b1;
                        // Fetches hold the select open for a continued burst
                        if (!burst) begin
                            cs_active <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.start) begin
            shift_out <= {req.write ? CMD_WRITE : CMD_READ, req.addr,
                          req.write ? req.wdata : 32'h0};
        end else if (busy && sclk_q) begin
            // Mode 0, sample while SCLK is high and advance on its falling edge
            shift_out <= {shift_out[62:0], 1'b0};
            shift_in <= {shift_in[30:0], spi_io_in[1]};
        end
    end

    assign rsp = '{done: done_q, rdata: shift_in};

    assign flash_cs_n = !(cs_active && sel_flash);
    assign ram_cs_n = !(cs_active && !sel_flash);
    assign spi_sclk = sclk_q;

    // io[0] carries MOSI, io[1] is input only
    assign spi_io_out = {3'b000, cs_active & shift_out[63]};
    assign spi_io_oe = {3'b000, cs_active};

endmodule

// File: src/access_arbiter.sv
// Fetch and data access arbiter FSM with one-word instruction prefetch buffer
`timescale 1ns/1ps

module access_arbiter import mem_ctl_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    input  logic [31:0] instr_addr,
    output logic [31:0] instr_data,
    output logic instr_ready,

    input  data_req_t mem_req,
    input  logic mem_valid,
    output logic [31:0] mem_rdata,
    output logic mem_done,

    output spi_req_t spi_req,
    input  spi_rsp_t spi_rsp,
    output logic fetch_active,
    output logic data_in_flash
);

    typedef enum logic [2:0] {
        ACCESS_IDLE,
        ACCESS_ACTIVE,
        ACCESS_NEXT_INSTR,
        ACCESS_PAUSE,
        ACCESS_STOP
    } state_t;

    state_t state;

    // Captured data request, held until its transfer completes
    logic pend;
    data_req_t pend_req;

    logic [31:0] fetch_addr;
    logic [31:0] seq_addr;
    logic [31:0] instr_q;
    logic [31:0] next_q;
    logic instr_valid;
    logic is_fetch;
    logic in_flash;

    logic start_q;
    logic stop_q;
    logic cont_q;
    logic write_q;
    logic [SPI_ADDR_W-1:0] addr_q;
    logic [5:0] len_q;
    logic [31:0] wdata_q;

    logic addr_hit;
    logic seq_hit;
    logic fetch_busy;
    logic preempt;
    logic start_data;
    logic start_fetch;
    logic first_done;
    logic next_jump;
    logic next_done;
    logic pause_adv;
    logic pause_jump;

    assign seq_addr = fetch_addr + 32'd4;
    assign addr_hit = (instr_addr == fetch_addr);
    assign seq_hit = (instr_addr == seq_addr);

    assign instr_ready = instr_valid && addr_hit;

    assign fetch_busy = (state == ACCESS_ACTIVE) || (state == ACCESS_NEXT_INSTR) ||
                        (state == ACCESS_PAUSE);
    // Data wins and cuts a running fetch burst short
    assign preempt = pend && is_fetch && fetch_busy;

    assign start_data = (state == ACCESS_IDLE) && pend;
    assign start_fetch = (state == ACCESS_IDLE) && !pend && !instr_ready;
    assign first_done = (state == ACCESS_ACTIVE) && !preempt && spi_rsp.done;

    assign next_jump = (state == ACCESS_NEXT_INSTR) && !preempt && !addr_hit && !seq_hit;
    assign next_done = (state == ACCESS_NEXT_INSTR) && !preempt && !next_jump && spi_rsp.done;

    // PAUSE is only entered with the next word already in next_q
    assign pause_adv = (state == ACCESS_PAUSE) && !preempt && !addr_hit && seq_hit;
    assign pause_jump = (state == ACCESS_PAUSE) && !preempt && !addr_hit && !pause_adv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ACCESS_IDLE;
            pend <= 1'b0;
            instr_valid <= 1'b0;
            is_fetch <= 1'b0;
            in_flash <= 1'b0;
            start_q <= 1'b0;
            stop_q <= 1'b0;
            cont_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            stop_q <= 1'b0;
            cont_q <= 1'b0;
            if (preempt) begin
                // instr_data stays valid for fetch_addr and only the burst is lost
                stop_q <= 1'b1;
                state <= ACCESS_STOP;
            end else begin
                case (state)
                    ACCESS_IDLE: begin
                        if (start_data) begin
                            start_q <= 1'b1;
                            is_fetch <= 1'b0;
                            in_flash <= (pend_req.addr[31:24] == FLASH_BASE);
                            state <= ACCESS_ACTIVE;
                        end else if (start_fetch) begin
                            start_q <= 1'b1;
                            is_fetch <= 1'b1;
                            in_flash <= 1'b0;
                            instr_valid <= 1'b0;
                            state <= ACCESS_ACTIVE;
                        end
                    end
                    ACCESS_ACTIVE: begin
                        if (spi_rsp.done) begin
                            if (is_fetch) begin
                                instr_valid <= 1'b1;
                                cont_q <= 1'b1;
                                state <= ACCESS_NEXT_INSTR;
                            end else begin
                                pend <= 1'b0;
                                in_flash <= 1'b0;
                                state <= ACCESS_IDLE;
                            end
                        end
                    end
                    ACCESS_NEXT_INSTR: begin
                        if (next_jump) begin
                            instr_valid <= 1'b0;
                            stop_q <= 1'b1;
                            state <= ACCESS_STOP;
                        end else if (spi_rsp.done) begin
                            state <= ACCESS_PAUSE;
                        end
                    end
                    ACCESS_PAUSE: begin
                        if (pause_adv) begin
                            cont_q <= 1'b1;
                            state <= ACCESS_NEXT_INSTR;
                        end else if (pause_jump) begin
                            instr_valid <= 1'b0;
                            stop_q <= 1'b1;
                            state <= ACCESS_STOP;
                        end
                    end
                    ACCESS_STOP: begin
                        is_fetch <= 1'b0;
                        in_flash <= 1'b0;
                        state <= ACCESS_IDLE;
                    end
                    default: state <= ACCESS_IDLE;
                endcase
            end
            if (mem_valid) begin
                pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            pend_req <= mem_req;
        end
        if (start_data) begin
            write_q <= pend_req.we;
            addr_q <= pend_req.addr[SPI_ADDR_W-1:0];
            len_q <= data_len_bits(pend_req.funct3);
            wdata_q <= store_lanes(pend_req.wdata, pend_req.funct3);
        end else if (start_fetch) begin
            write_q <= 1'b0;
            addr_q <= instr_addr[SPI_ADDR_W-1:0];
            len_q <= data_len_bits(F3_WORD);
            wdata_q <= 32'h0;
            fetch_addr <= instr_addr;
        end
        if (first_done && is_fetch) begin
            instr_q <= load_extend(spi_rsp.rdata, F3_WORD);
        end else if (pause_adv) begin
            // Sequential PC served from the prefetch buffer
            instr_q <= next_q;
            fetch_addr <= instr_addr;
        end
        if (next_done) begin
            next_q <= load_extend(spi_rsp.rdata, F3_WORD);
        end
    end

    assign instr_data = instr_q;

    // Data response goes straight out and data_port registers it
    assign mem_done = (state == ACCESS_ACTIVE) && !is_fetch && spi_rsp.done;
    assign mem_rdata = load_extend(spi_rsp.rdata, pend_req.funct3);

    assign spi_req = '{start: start_q, stop: stop_q, cont: cont_q, write: write_q,
                       addr: addr_q, len: len_q, wdata: wdata_q};

    assign fetch_active = is_fetch;
    assign data_in_flash = in_flash;

endmodule

// File: src/data_port.sv
// Data address decode, GPIO output register and data response merge
`timescale 1ns/1ps

module data_port import mem_ctl_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    input  data_req_t data_req,
    output data_req_t mem_req,
    output logic mem_valid,
    input  logic [31:0] arb_rdata,
    input  logic arb_done,
    output logic [31:0] mem_rdata,
    output logic mem_ready,

    output logic [GPIO_WIDTH-1:0] gpio_out
);

    logic strobe;
    logic mem_hit;
    logic gpio_hit;
    logic local_hit;
    logic [GPIO_WIDTH-1:0] gpio_q;

    assign strobe = data_req.we | data_req.re;
    assign mem_hit = (data_req.addr[31:24] == FLASH_BASE) || (data_req.addr[31:24] == PSRAM_BASE);
    assign gpio_hit = (data_req.addr[31:8] == GPIO_BASE);

    // Anything outside flash and PSRAM is answered here, unmapped reads give zero
    assign local_hit = strobe && !mem_hit;

    assign mem_req = data_req;
    assign mem_valid = strobe && mem_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_q <= '0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= local_hit || arb_done;
            if (local_hit && gpio_hit && data_req.we) begin
                gpio_q <= data_req.wdata[GPIO_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arb_done) begin
            mem_rdata <= arb_rdata;
        end else if (local_hit) begin
            mem_rdata <= gpio_hit ? {{(32 - GPIO_WIDTH){1'b0}}, gpio_q} : 32'h0;
        end
    end

    assign gpio_out = gpio_q;

endmodule

// File: src/mem_ctl.sv
// Memory controller top with arbiter, data port and SPI master instances
`timescale 1ns/1ps

module mem_ctl import mem_ctl_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    // Instruction side
    input  logic [31:0] instr_addr,
    output logic [31:0] instr_data,
    output logic instr_ready,

    // Data side
    input  data_req_t data_req,
    output logic [31:0] mem_rdata,
    output logic mem_ready,

    output logic [GPIO_WIDTH-1:0] gpio_out,

    // Shared serial bus
    output logic flash_cs_n,
    output logic ram_cs_n,
    output logic spi_sclk,
    input  logic [3:0] spi_io_in,
    output logic [3:0] spi_io_out,
    output logic [3:0] spi_io_oe
);

    data_req_t mem_req;
    logic mem_valid;
    logic [31:0] arb_rdata;
    logic arb_done;
    spi_req_t spi_req;
    spi_rsp_t spi_rsp;
    logic fetch_active;
    logic data_in_flash;

    access_arbiter u_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .instr_addr(instr_addr),
        .instr_data(instr_data),
        .instr_ready(instr_ready),
        .mem_req(mem_req),
        .mem_valid(mem_valid),
        .mem_rdata(arb_rdata),
        .mem_done(arb_done),
        .spi_req(spi_req),
        .spi_rsp(spi_rsp),
        .fetch_active(fetch_active),
        .data_in_flash(data_in_flash)
    );

    data_port u_data_port (
        .clk(clk),
        .rst_n(rst_n),
        .data_req(data_req),
        .mem_req(mem_req),
        .mem_valid(mem_valid),
        .arb_rdata(arb_rdata),
        .arb_done(arb_done),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .gpio_out(gpio_out)
    );

    spi_master u_spi (
        .clk(clk),
        .rst_n(rst_n),
        .req(spi_req),
        .fetch_active(fetch_active),
        .data_in_flash(data_in_flash),
        .rsp(spi_rsp),
        .flash_cs_n(flash_cs_n),
        .ram_cs_n(ram_cs_n),
        .spi_sclk(spi_sclk),
        .spi_io_in(spi_io_in),
        .spi_io_out(spi_io_out),
        .spi_io_oe(spi_io_oe)
    );

endmodule

// File: test/spi_mem_model.sv
// Behavioral single-line SPI flash and PSRAM with byte arrays selected by chip select
`timescale 1ns/1ps

module spi_mem_model import mem_ctl_pkg::*; (
    input  logic flash_cs_n,
    input  logic ram_cs_n,
    input  logic spi_sclk,
    input  logic mosi,
    output logic miso
);

    logic [7:0] flash [0:1023];
    logic [7:0] ram [0:1023];

    logic cs_idle;
    int cnt;
    int idx;
    logic [7:0] cmd;
    logic [23:0] addr;
    logic [7:0] wbyte;
    logic [7:0] rbyte;

    assign cs_idle = flash_cs_n && ram_cs_n;

    initial begin
        miso = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            ram[i] = 8'h00;
        end
    end

    // Device samples MOSI on the rising edge
    always @(posedge spi_sclk or posedge cs_idle) begin
        if (cs_idle) begin
            cnt = 0;
        end else begin
            if (cnt < 8) begin
                cmd = {cmd[6:0], mosi};
            end else if (cnt < 32) begin
                addr = {addr[22:0], mosi};
            end else if (cmd == CMD_WRITE && !ram_cs_n) begin
                idx = cnt - 32;
                wbyte = {wbyte[6:0], mosi};
                if (idx % 8 == 7) begin
                    ram[(addr + idx / 8) % 1024] = wbyte;
                end
            end
            cnt = cnt + 1;
        end
    end

    // Read data changes on the falling edge, ahead of the master's sample
    always @(negedge spi_sclk) begin
        if (!cs_idle && cnt >= 32 && cmd == CMD_READ) begin
            idx = cnt - 32;
            rbyte = !flash_cs_n ? flash[(addr + idx / 8) % 1024] : ram[(addr + idx / 8) % 1024];
            miso = rbyte[7 - idx % 8];
        end
    end

endmodule

// File: test/mem_ctl_checker.sv
// Result checker comparing DUT outputs with expected values and tracking mem_ready latency
`timescale 1ns/1ps

module mem_ctl_checker (
    input  logic clk,
    input  logic [31:0] instr_data,
    input  logic instr_ready,
    input  logic [31:0] mem_rdata,
    input  logic mem_ready,
    input  logic [7:0] gpio_out,
    input  logic ram_cs_n,
    input  logic data_strobe,
    input  logic check_stb,
    input  int check_id,
    input  logic [2:0] check_sel,
    input  logic [31:0] check_exp,
    input  logic report,
    input  int timeouts,
    output int errors
);

    int checks;
    int cycles;
    logic [31:0] latency;
    logic [31:0] actual;
    string name;

    initial begin
        errors = 0;
        checks = 0;
        cycles = 0;
        latency = '0;
    end

    // Cycles from the request strobe to mem_ready
    always @(negedge clk) begin
        if (data_strobe) begin
            cycles = 0;
        end else begin
            cycles = cycles + 1;
            if (mem_ready) begin
                latency = cycles;
            end
        end
    end

    always @(negedge clk) begin
        if (check_stb) begin
            case (check_sel)
                3'd0: begin
                    name = "instr_data";
                    actual = instr_data;
                end
                3'd1: begin
                    name = "instr_ready";
                    actual = {31'h0, instr_ready};
                end
                3'd2: begin
                    name = "mem_rdata";
                    actual = mem_rdata;
                end
                3'd3: begin
                    name = "gpio_out";
                    actual = {24'h0, gpio_out};
                end
                3'd4: begin
                    name = "mem_ready latency";
                    actual = latency;
                end
                3'd5: begin
                    name = "ram_cs_n";
                    actual = {31'h0, ram_cs_n};
                end
                default: begin
                    name = "unknown check";
                    actual = 'x;
                end
            endcase
            checks++;
            if (actual !== check_exp) begin
                errors++;
                $display("ERROR time=%0t test %0d %s expected %h actual %h",
                         $time, check_id, name, check_exp, actual);
            end else begin
                $display("test %0d %s ok (%h)", check_id, name, actual);
            end
        end
        if (report) begin
            $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
        end
    end

endmodule

// File: test/mem_ctl_props.sv
// Concurrent chip select, mem_ready and output enable assertions bound to mem_ctl
`timescale 1ns/1ps

module mem_ctl_props (
    input logic clk,
    input logic rst_n,
    input logic flash_cs_n,
    input logic ram_cs_n,
    input logic mem_ready,
    input logic [3:0] spi_io_oe
);

    int failures;

    initial begin
        failures = 0;
    end

    a_cs_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(!flash_cs_n && !ram_cs_n))
        else begin
            failures++;
            $error("flash and RAM selected together");
        end

    a_ready_single: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |=> !mem_ready)
        else begin
            failures++;
            $error("mem_ready high two cycles in a row");
        end

    a_oe_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (flash_cs_n && ram_cs_n) |-> (spi_io_oe == 4'b0000))
        else begin
            failures++;
            $error("io driven with no device selected");
        end

endmodule

bind mem_ctl mem_ctl_props u_props (
    .clk(clk),
    .rst_n(rst_n),
    .flash_cs_n(flash_cs_n),
    .ram_cs_n(ram_cs_n),
    .mem_ready(mem_ready),
    .spi_io_oe(spi_io_oe)
);

// File: test/mem_ctl_tb.sv
// Testbench top with clock, reset, LFSR, stimulus table and sequencing loop
`timescale 1ns/1ps

module mem_ctl_tb import mem_ctl_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;
    localparam logic [2:0] K_FETCH = 3'd0;
    localparam logic [2:0] K_STORE = 3'd1;
    localparam logic [2:0] K_LOAD = 3'd2;
    localparam logic [2:0] K_GPIO_W = 3'd3;
    localparam logic [2:0] K_GPIO_R = 3'd4;
    localparam logic [2:0] K_STORE_FETCH = 3'd5;

    typedef struct packed {
        logic [2:0] kind;
        logic [31:0] addr;
        logic [31:0] faddr;
        logic [31:0] wdata;
        logic [2:0] funct3;
        logic [31:0] exp;
        logic [31:0] fexp;
    } entry_t;

    logic clk;
    logic rst_n;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic instr_ready;
    data_req_t data_req;
    logic [31:0] mem_rdata;
    logic mem_ready;
    logic [7:0] gpio_out;
    logic flash_cs_n;
    logic ram_cs_n;
    logic spi_sclk;
    logic miso;
    logic [3:0] spi_io_out;
    logic [3:0] spi_io_oe;

    logic check_stb;
    int check_id;
    logic [2:0] check_sel;
    logic [31:0] check_exp;
    logic report;
    int timeouts;
    int errors;

    logic [31:0] lfsr_q;
    logic [7:0] flash_m [0:1023];
    logic [7:0] ram_m [0:1023];
    logic [7:0] gpio_m;
    entry_t table_q[$];

    mem_ctl u_dut (
        .clk(clk),
        .rst_n(rst_n),
        .instr_addr(instr_addr),
        .instr_data(instr_data),
        .instr_ready(instr_ready),
        .data_req(data_req),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .gpio_out(gpio_out),
        .flash_cs_n(flash_cs_n),
        .ram_cs_n(ram_cs_n),
        .spi_sclk(spi_sclk),
        .spi_io_in({2'b00, miso, 1'b0}),
        .spi_io_out(spi_io_out),
        .spi_io_oe(spi_io_oe)
    );

    spi_mem_model u_mem (
        .flash_cs_n(flash_cs_n),
        .ram_cs_n(ram_cs_n),
        .spi_sclk(spi_sclk),
        .mosi(spi_io_out[0]),
        .miso(miso)
    );

    mem_ctl_checker u_checker (
        .clk(clk),
        .instr_data(instr_data),
        .instr_ready(instr_ready),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .gpio_out(gpio_out),
        .ram_cs_n(ram_cs_n),
        .data_strobe(data_req.we | data_req.re),
        .check_stb(check_stb),
        .check_id(check_id),
        .check_sel(check_sel),
        .check_exp(check_exp),
        .report(report),
        .timeouts(timeouts),
        .errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [7:0] byte_at(input logic [31:0] a);
        return (a[31:24] == FLASH_BASE) ? flash_m[a[9:0]] : ram_m[a[9:0]];
    endfunction

    // Little-endian bytes, every load width zero-extended
    function automatic logic [31:0] load_value(input logic [31:0] a, input logic [2:0] f3);
        case (f3[1:0])
            2'b00: return {24'h0, byte_at(a)};
            2'b01: return {16'h0, byte_at(a + 1), byte_at(a)};
            default: return {byte_at(a + 3), byte_at(a + 2), byte_at(a + 1), byte_at(a)};
        endcase
    endfunction

    function automatic void store_mirror(input logic [31:0] a, input logic [31:0] w,
                                         input logic [2:0] f3);
        ram_m[a[9:0]] = w[7:0];
        if (f3[1:0] != 2'b00) begin
            ram_m[(a[9:0] + 1) % 1024] = w[15:8];
        end
        if (f3[1:0] == 2'b10) begin
            ram_m[(a[9:0] + 2) % 1024] = w[23:16];
            ram_m[(a[9:0] + 3) % 1024] = w[31:24];
        end
    endfunction

    task automatic add_entry(input logic [2:0] kind, input logic [31:0] a,
                             input logic [31:0] fa, input logic [2:0] f3);
        entry_t e;
        logic [31:0] w;
        e = '0;
        e.kind = kind;
        e.addr = a;
        e.faddr = fa;
        e.funct3 = f3;
        case (kind)
            K_FETCH: e.exp = load_value(a, F3_WORD);
            K_LOAD: e.exp = load_value(a, f3);
            K_GPIO_R: e.exp = {24'h0, gpio_m};
            K_GPIO_W: begin
                take_bits(32, w);
                e.wdata = w;
                gpio_m = w[7:0];
                e.exp = {24'h0, gpio_m};
            end
            default: begin
                take_bits(32, w);
                e.wdata = w;
                store_mirror(a, w, f3);
                e.fexp = load_value(fa, F3_WORD);
            end
        endcase
        table_q.push_back(e);
    endtask

    task automatic pulse_check(input int id, input logic [2:0] sel, input logic [31:0] exp);
        check_stb <= 1'b1;
        check_id <= id;
        check_sel <= sel;
        check_exp <= exp;
        @(posedge clk);
        check_stb <= 1'b0;
    endtask

    task automatic wait_instr(input int id, output bit ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!instr_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = instr_ready;
        if (!ok) begin
            $display("test %0d: instr_ready never came, fetch timed out", id);
            timeouts++;
        end
    endtask

    task automatic wait_mem(input int id, output bit ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!mem_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = mem_ready;
        if (!ok) begin
            $display("test %0d: mem_ready never came, data access timed out", id);
            timeouts++;
        end
    endtask

    task automatic issue_data(input entry_t e);
        @(posedge clk);
        data_req <= '{addr: e.addr, wdata: e.wdata, funct3: e.funct3,
                      we: (e.kind != K_LOAD && e.kind != K_GPIO_R),
                      re: (e.kind == K_LOAD || e.kind == K_GPIO_R)};
        @(posedge clk);
        data_req.we <= 1'b0;
        data_req.re <= 1'b0;
    endtask

    task automatic run_entry(input int id, input entry_t e);
        bit ok;
        case (e.kind)
            K_FETCH: begin
                @(posedge clk);
                instr_addr <= e.addr;
                // Ready must drop as soon as the address moves
                pulse_check(id, 3'd1, 32'h0);
                wait_instr(id, ok);
                @(posedge clk);
                if (ok) pulse_check(id, 3'd0, e.exp);
            end
            K_STORE_FETCH: begin
                @(posedge clk);
                instr_addr <= e.faddr;
                repeat (10) @(posedge clk);
                issue_data(e);
                wait_mem(id, ok);
                @(posedge clk);
                if (ok) pulse_check(id, 3'd5, 32'h1);
                wait_instr(id, ok);
                @(posedge clk);
                if (ok) pulse_check(id, 3'd0, e.fexp);
            end
            default: begin
                issue_data(e);
                wait_mem(id, ok);
                @(posedge clk);
                if (ok) begin
                    if (e.kind == K_LOAD) pulse_check(id, 3'd2, e.exp);
                    // A finished store leaves the RAM deselected
                    else if (e.kind == K_STORE) pulse_check(id, 3'd5, 32'h1);
                    else if (e.kind == K_GPIO_W) pulse_check(id, 3'd3, e.exp);
                    else begin
                        pulse_check(id, 3'd2, e.exp);
                        pulse_check(id, 3'd4, 32'd1);
                    end
                end
            end
        endcase
    endtask

    initial begin
        logic [31:0] v;
        rst_n = 1'b0;
        instr_addr = 32'h8000_0000;
        data_req = '0;
        check_stb = 1'b0;
        check_id = 0;
        check_sel = 3'd0;
        check_exp = '0;
        report = 1'b0;
        timeouts = 0;
        lfsr_q = 32'hf75d39f4;
        gpio_m = 8'h00;
        for (int a = 0; a < 1024; a++) begin
            take_bits(8, v);
            flash_m[a] = v[7:0];
            u_mem.flash[a] = v[7:0];
            ram_m[a] = 8'h00;
        end
        add_entry(K_FETCH, 32'h8000_0010, '0, F3_WORD);
        add_entry(K_FETCH, 32'h8000_0014, '0, F3_WORD);
        add_entry(K_FETCH, 32'h8000_0018, '0, F3_WORD);
        add_entry(K_FETCH, 32'h8000_0200, '0, F3_WORD);
        add_entry(K_STORE, 32'h0000_0040, '0, 3'b010);
        add_entry(K_STORE, 32'h0000_0044, '0, 3'b001);
        add_entry(K_STORE, 32'h0000_0048, '0, 3'b000);
        add_entry(K_LOAD, 32'h0000_0040, '0, 3'b010);
        add_entry(K_LOAD, 32'h0000_0044, '0, 3'b101);
        add_entry(K_LOAD, 32'h0000_0048, '0, 3'b100);
        add_entry(K_LOAD, 32'h0000_0044, '0, 3'b010);
        add_entry(K_LOAD, 32'h8000_0020, '0, 3'b010);
        add_entry(K_GPIO_W, 32'h4000_0000, '0, 3'b010);
        add_entry(K_GPIO_R, 32'h4000_0004, '0, 3'b010);
        add_entry(K_STORE_FETCH, 32'h0000_0080, 32'h8000_0300, 3'b010);
        add_entry(K_LOAD, 32'h0000_0080, '0, 3'b010);

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        foreach (table_q[i]) begin
            run_entry(i, table_q[i]);
        end

        @(posedge clk);
        report <= 1'b1;
        @(posedge clk);
        report <= 1'b0;
        @(posedge clk);
        if (errors == 0 && timeouts == 0 && u_dut.u_props.failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: mem_ctl.f
src/mem_ctl_pkg.sv
src/spi_master.sv
src/access_arbiter.sv
src/data_port.sv
src/mem_ctl.sv
test/spi_mem_model.sv
test/mem_ctl_checker.sv
test/mem_ctl_props.sv
test/mem_ctl_tb.sv
